// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the io_links testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_io_links

./obj_dir/Vtb_io_links | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"

// ==== sim/io_links_checker.sv ====
`timescale 1ns/1ps

module io_links_checker (
	input logic                                                  in_clk160,
	input logic                                                  rst_n,
	input logic [io_links_pkg::n_links-1:0]                      in_tvalid,
	input logic [io_links_pkg::n_links-1:0]                      in_tready,
	input logic [io_links_pkg::n_links*io_links_pkg::word_w-1:0] out_tdata,
	input logic [io_links_pkg::n_links-1:0]                      out_tvalid
);
	import io_links_pkg::*;

	logic [word_w-1:0] exp_q [$];
	logic [word_w-1:0] expected;
	logic [word_w-1:0] actual;
	string             test_name = "idle";
	int                link_sel = 0;
	bit                check_lat = 1'b0;
	bit                accept_d = 1'b0;
	// Monitor errors and direct check errors are kept apart
	int                word_errs = 0;
	int                misc_errs = 0;
	int                errs_at_start = 0;

	task automatic start_test(input string name, input int link, input bit lat);
		exp_q.delete();
		test_name     = name;
		link_sel      = link;
		check_lat     = lat;
		misc_errs     = 0;
		errs_at_start = word_errs;
	endtask

	task automatic expect_word(input logic [word_w-1:0] w);
		exp_q.push_back(w);
	endtask

	task automatic flag(input string msg);
		$display("Error in %s: %s", test_name, msg);
		misc_errs++;
	endtask

	task automatic compare(input string label, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("Fail %s %s: expected %0h, actual %0h",
				test_name, label, exp_val, act_val);
			misc_errs++;
		end
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic int errors();
		return word_errs - errs_at_start + misc_errs;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////
	always @(posedge in_clk160) begin
		if (rst_n) begin
			for (int i = 0; i < n_links; i++) begin
				if (out_tvalid[i]) begin
					actual = out_tdata[i*word_w +: word_w];
					if (i != link_sel) begin
						$display("Error in %s: unexpected word %02h on link %0d",
							test_name, actual, i);
						word_errs++;
					end else if (exp_q.size() == 0) begin
						$display("Error in %s: extra word %02h on link %0d",
							test_name, actual, i);
						word_errs++;
					end else begin
						expected = exp_q.pop_front();
						if (actual !== expected) begin
							$display("Fail %s: expected %02h, actual %02h",
								test_name, expected, actual);
							word_errs++;
						end
					end
					// Bypass words follow their acceptance by one cycle
					if (i == link_sel && check_lat && !accept_d) begin
						$display("Error in %s: bypass word came later than one cycle",
							test_name);
						word_errs++;
					end
				end
			end
			accept_d = in_tvalid[link_sel] && in_tready[link_sel];
		end
	end

endmodule

// ==== sim/io_links_patterns.txt ====
// One record per line, all hex
// name link ctrl gaps n_in in0 in1 in2 in3 in4 in5 n_exp exp0 exp1 exp2 exp3 exp4 exp5
// ctrl is the link control word; gaps 1 puts random idle cycles between words

// loop_plain
00 00 00 00 06 12 34 56 78 9A BC 06 12 34 56 78 9A BC
// loop_invert
01 01 08 00 04 00 FF 5A C3 00 00 04 00 FF 5A C3 00 00
// loop_gaps
02 03 00 01 06 DE AD BE EF 01 80 06 DE AD BE EF 01 80
// offset3
03 02 03 00 04 A5 3C F0 0F 00 00 03 29 E7 80 00 00 00
// offset3_invert_gaps
04 02 0B 01 04 A5 3C F0 0F 00 00 03 29 E7 80 00 00 00
// bypass
05 01 20 01 03 11 22 33 00 00 00 03 11 22 33 00 00 00
// tristate
06 00 10 00 02 44 55 00 00 00 00 00 00 00 00 00 00 00
// offset5_gaps
07 03 05 01 03 81 7E C4 00 00 00 02 2F D8 00 00 00 00

// ==== sim/tb_io_links.sv ====
`timescale 1ns/1ps

module tb_io_links;
	import io_links_pkg::*;

	localparam int rec_len   = 18;
	localparam int n_records = 8;
	localparam int max_wait  = 200;

	logic                        in_clk160;
	logic                        rst_n;
	logic [addr_w-1:0]           paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [data_w-1:0]           pwdata;
	logic [data_w-1:0]           prdata;
	logic                        pready;
	logic                        pslverr;
	logic [n_links*word_w-1:0]   in_tdata;
	logic [n_links-1:0]          in_tvalid;
	logic [n_links-1:0]          in_tready;
	logic [n_links*word_w-1:0]   out_tdata;
	logic [n_links-1:0]          out_tvalid;

	logic [7:0] pat [0:n_records*rec_len-1];
	int         exp_count [n_links];
	int         pass_count;
	int         fail_count;
	integer     seed;

	io_links_top io_links_top_inst (
		.in_clk160  (in_clk160),
		.rst_n      (rst_n),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.in_tdata   (in_tdata),
		.in_tvalid  (in_tvalid),
		.in_tready  (in_tready),
		.out_tdata  (out_tdata),
		.out_tvalid (out_tvalid)
	);

	io_links_checker checker_inst (
		.in_clk160  (in_clk160),
		.rst_n      (rst_n),
		.in_tvalid  (in_tvalid),
		.in_tready  (in_tready),
		.out_tdata  (out_tdata),
		.out_tvalid (out_tvalid)
	);

	initial begin
		in_clk160 = 1'b0;
		forever #4 in_clk160 = ~in_clk160;
	end

	function automatic logic [addr_w-1:0] ctrl_addr(input int link);
		return ctrl_base + addr_w'(4 * link);
	endfunction

	function automatic logic [addr_w-1:0] stat_addr(input int link);
		return stat_base + addr_w'(4 * link);
	endfunction

	function automatic string record_name(input int r);
		case (r)
			0: return "loop_plain";
			1: return "loop_invert";
			2: return "loop_gaps";
			3: return "offset3";
			4: return "offset3_invert_gaps";
			5: return "bypass";
			6: return "tristate";
			default: return "offset5_gaps";
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB and stream tasks entered on a falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic apb_access(input logic wr, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata,
		output logic err);
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge in_clk160);
		penable = 1'b1;
		// Sample well inside the access phase
		#1;
		rdata = prdata;
		err   = pslverr;
		if (!pready)
			checker_inst.flag("pready was low in an access phase");
		@(negedge in_clk160);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		logic [data_w-1:0] rdata;
		logic              err;
		apb_access(1'b1, addr, data, rdata, err);
	endtask

	task automatic send_word(input int link, input logic [word_w-1:0] w);
		int t;
		in_tdata[link*word_w +: word_w] = w;
		in_tvalid[link] = 1'b1;
		t = 0;
		while (!in_tready[link] && t < max_wait) begin
			@(negedge in_clk160);
			t++;
		end
		if (!in_tready[link])
			checker_inst.flag("input word was not accepted in time");
		@(negedge in_clk160);
		in_tvalid[link] = 1'b0;
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (checker_inst.pending() != 0 && t < max_wait) begin
			@(negedge in_clk160);
			t++;
		end
		if (checker_inst.pending() != 0)
			checker_inst.flag("expected word did not arrive in time");
	endtask

	task automatic finish_test(input string name);
		if (checker_inst.errors() == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, checker_inst.errors());
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic register_test();
		logic [data_w-1:0] rdata;
		logic              err;
		checker_inst.start_test("register_access", 0, 1'b0);
		for (int i = 0; i < n_links; i++)
			apb_write(ctrl_addr(i), data_w'(8'h15 + 8'(i * 23)));
		for (int i = 0; i < n_links; i++) begin
			apb_access(1'b0, ctrl_addr(i), '0, rdata, err);
			checker_inst.compare("control readback", data_w'(8'h15 + 8'(i * 23)), rdata);
			checker_inst.compare("mapped pslverr", 32'h0, {31'b0, err});
		end
		apb_write(global_addr, 32'h3);
		apb_access(1'b0, global_addr, '0, rdata, err);
		checker_inst.compare("global readback", 32'h1, rdata);
		apb_access(1'b0, 8'h24, '0, rdata, err);
		checker_inst.compare("unmapped pslverr", 32'h1, {31'b0, err});
		apb_write(global_addr, '0);
		for (int i = 0; i < n_links; i++)
			apb_write(ctrl_addr(i), '0);
		finish_test("register_access");
	endtask

	task automatic run_record(input int r);
		int                base;
		int                link;
		int                n_in;
		int                n_exp;
		int                gap;
		string             name;
		logic [7:0]        ctrl;
		logic [data_w-1:0] rdata;
		logic              err;
		base  = r * rec_len;
		name  = record_name(int'(pat[base]));
		link  = int'(pat[base + 1]);
		ctrl  = pat[base + 2];
		n_in  = int'(pat[base + 4]);
		n_exp = int'(pat[base + 11]);
		// Pulse link reset so bits held from an earlier stream are dropped
		apb_write(ctrl_addr(link), data_w'(ctrl | 8'(1 << link_rst_bit)));
		apb_write(ctrl_addr(link), data_w'(ctrl));
		checker_inst.start_test(name, link, ctrl[bypass_bit]);
		for (int i = 0; i < n_exp; i++)
			checker_inst.expect_word(pat[base + 12 + i]);
		for (int i = 0; i < n_in; i++) begin
			if (pat[base + 3][0]) begin
				gap = $random(seed) & 7;
				repeat (gap) @(negedge in_clk160);
			end
			send_word(link, pat[base + 5 + i]);
		end
		wait_drain();
		// Quiet time lets stray words show up at the monitor
		repeat (16) @(negedge in_clk160);
		if (!ctrl[bypass_bit] && !ctrl[tristate_bit])
			exp_count[link] += n_exp;
		apb_access(1'b0, stat_addr(link), '0, rdata, err);
		checker_inst.compare("word counter", data_w'(exp_count[link]), rdata);
		finish_test(name);
	endtask

	task automatic link_reset_test();
		int lk;
		lk = 2;
		checker_inst.start_test("link_reset", lk, 1'b0);
		apb_write(ctrl_addr(lk), data_w'(8'(1 << link_rst_bit)));
		in_tdata[lk*word_w +: word_w] = 8'h96;
		in_tvalid[lk] = 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(negedge in_clk160);
			if (in_tready[lk])
				checker_inst.flag("in_tready went high while the link was in reset");
		end
		in_tvalid[lk] = 1'b0;
		apb_write(ctrl_addr(lk), '0);
		// A fresh stream starts again at bit 0
		checker_inst.expect_word(8'hC3);
		checker_inst.expect_word(8'h5A);
		send_word(lk, 8'hC3);
		send_word(lk, 8'h5A);
		wait_drain();
		repeat (16) @(negedge in_clk160);
		exp_count[lk] += 2;
		finish_test("link_reset");
	endtask

	task automatic counter_test();
		logic [data_w-1:0] rdata;
		logic              err;
		checker_inst.start_test("word_counters", 0, 1'b0);
		for (int i = 0; i < n_links; i++) begin
			apb_access(1'b0, stat_addr(i), '0, rdata, err);
			checker_inst.compare("counter before clear", data_w'(exp_count[i]), rdata);
		end
		apb_write(global_addr, data_w'(1 << clear_cnt_bit));
		apb_access(1'b0, global_addr, '0, rdata, err);
		checker_inst.compare("global clear bit", 32'h0, rdata);
		for (int i = 0; i < n_links; i++) begin
			apb_access(1'b0, stat_addr(i), '0, rdata, err);
			checker_inst.compare("counter after clear", 32'h0, rdata);
			exp_count[i] = 0;
		end
		finish_test("word_counters");
	endtask

	initial begin
		seed       = 95808;
		pass_count = 0;
		fail_count = 0;
		rst_n      = 1'b0;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		in_tdata   = '0;
		in_tvalid  = '0;
		for (int i = 0; i < n_links; i++)
			exp_count[i] = 0;
		$readmemh("sim/io_links_patterns.txt", pat);
		repeat (10) @(posedge in_clk160);
		@(negedge in_clk160);
		rst_n = 1'b1;
		register_test();
		for (int r = 0; r < n_records; r++)
			run_record(r);
		link_reset_test();
		counter_test();
		$display("Tests passed: %0d, tests with errors: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== source/apb_link_regs.sv ====
`timescale 1ns/1ps

module apb_link_regs (
	input  logic                            in_clk160,
	input  logic                            rst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [io_links_pkg::addr_w-1:0] paddr,
	input  logic [io_links_pkg::data_w-1:0] pwdata,
	output logic [io_links_pkg::data_w-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr,
	link_cfg_if.regs                        cfg [io_links_pkg::n_links]
);
	import io_links_pkg::*;

	logic [ctrl_w-1:0]  ctrl_q  [n_links];
	logic [count_w-1:0] count_q [n_links];
	logic [n_links-1:0] ctrl_sel;
	logic [n_links-1:0] stat_sel;
	logic [n_links-1:0] word_done;
	logic               global_sel;
	logic               global_rst_q;
	logic               access;
	logic               wr_en;
	logic               addr_hit;

	assign access = psel && penable;
	assign wr_en  = access && pwrite;

	////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < n_links; i++) begin
			ctrl_sel[i] = (paddr == ctrl_base + addr_w'(4 * i));
			stat_sel[i] = (paddr == stat_base + addr_w'(4 * i));
		end
	end

	assign global_sel = (paddr == global_addr);
	assign addr_hit   = (|ctrl_sel) || (|stat_sel) || global_sel;

	// Zero wait states
	assign pready  = 1'b1;
	assign pslverr = access && !addr_hit;

	////////////////////////////////////////////////////////////////////
	// Registers and word counters
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			global_rst_q <= 1'b0;
			for (int i = 0; i < n_links; i++) begin
				ctrl_q[i]  <= '0;
				count_q[i] <= '0;
			end
		end else begin
			if (wr_en && global_sel)
				global_rst_q <= pwdata[global_rst_bit];
			for (int i = 0; i < n_links; i++) begin
				if (wr_en && ctrl_sel[i])
					ctrl_q[i] <= pwdata[ctrl_w-1:0];
				// Clear bit acts only on the write and never holds
				if (wr_en && global_sel && pwdata[clear_cnt_bit])
					count_q[i] <= '0;
				else if (word_done[i] && (count_q[i] != '1))
					count_q[i] <= count_q[i] + 1'b1;
			end
		end
	end

	// Read mux
	always_comb begin
		prdata = '0;
		for (int i = 0; i < n_links; i++) begin
			if (ctrl_sel[i])
				prdata[ctrl_w-1:0] = ctrl_q[i];
			if (stat_sel[i])
				prdata[count_w-1:0] = count_q[i];
		end
		if (global_sel)
			prdata[global_rst_bit] = global_rst_q;
	end

	// Fan out control fields to each lane
	for (genvar i = 0; i < n_links; i++) begin : g_cfg
		assign cfg[i].bit_offset = ctrl_q[i][offset_lsb +: offset_w];
		assign cfg[i].invert     = ctrl_q[i][invert_bit];
		assign cfg[i].tristate   = ctrl_q[i][tristate_bit];
		assign cfg[i].bypass     = ctrl_q[i][bypass_bit];
		assign cfg[i].lane_rst   = ctrl_q[i][link_rst_bit] || global_rst_q;
		assign word_done[i]      = cfg[i].word_done;
	end

endmodule

// ==== source/io_links_pkg.sv ====
package io_links_pkg;

	////////////////////////////////////////////////////////////////////
	// Link and payload sizes
	////////////////////////////////////////////////////////////////////
	localparam int n_links   = 4;
	localparam int word_w    = 8;
	localparam int offset_w  = 3;
	localparam int count_w   = 16;
	localparam int bit_cnt_w = $clog2(word_w);

	// Index of the final bit of a word within the serial stream
	localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(word_w - 1);

	////////////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////////////
	localparam int addr_w = 8;
	localparam int data_w = 32;

	localparam logic [addr_w-1:0] ctrl_base   = 8'h00;
	localparam logic [addr_w-1:0] stat_base   = 8'h10;
	localparam logic [addr_w-1:0] global_addr = 8'h20;

	// Per-link control word fields
	localparam int offset_lsb   = 0;
	localparam int invert_bit   = 3;
	localparam int tristate_bit = 4;
	localparam int bypass_bit   = 5;
	localparam int link_rst_bit = 6;
	localparam int ctrl_w       = link_rst_bit + 1;

	// Global register fields
	localparam int global_rst_bit = 0;
	localparam int clear_cnt_bit  = 1;

endpackage

// ==== source/io_links_top.sv ====
`timescale 1ns/1ps

module io_links_top (
	input  logic                                                 in_clk160,
	input  logic                                                 rst_n,
	input  logic [io_links_pkg::addr_w-1:0]                      paddr,
	input  logic                                                 psel,
	input  logic                                                 penable,
	input  logic                                                 pwrite,
	input  logic [io_links_pkg::data_w-1:0]                      pwdata,
	output logic [io_links_pkg::data_w-1:0]                      prdata,
	output logic                                                 pready,
	output logic                                                 pslverr,
	input  logic [io_links_pkg::n_links*io_links_pkg::word_w-1:0] in_tdata,
	input  logic [io_links_pkg::n_links-1:0]                     in_tvalid,
	output logic [io_links_pkg::n_links-1:0]                     in_tready,
	output logic [io_links_pkg::n_links*io_links_pkg::word_w-1:0] out_tdata,
	output logic [io_links_pkg::n_links-1:0]                     out_tvalid
);
	import io_links_pkg::*;

	// Pad model driven and sampled by the same link
	logic [n_links-1:0] line_bit;
	logic [n_links-1:0] line_en;

	link_cfg_if cfg_if [n_links] ();

	apb_link_regs regs_inst (
		.in_clk160 (in_clk160),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cfg       (cfg_if)
	);

	////////////////////////////////////////////////////////////////////
	// Lanes with loopback
	////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < n_links; i++) begin : g_lane
		link_lane lane_inst (
			.in_clk160    (in_clk160),
			.rst_n        (rst_n),
			.cfg          (cfg_if[i]),
			.in_tdata     (in_tdata[i*word_w +: word_w]),
			.in_tvalid    (in_tvalid[i]),
			.in_tready    (in_tready[i]),
			.out_tdata    (out_tdata[i*word_w +: word_w]),
			.out_tvalid   (out_tvalid[i]),
			.line_bit_out (line_bit[i]),
			.line_en_out  (line_en[i]),
			.line_bit_in  (line_bit[i]),
			.line_en_in   (line_en[i])
		);
	end

endmodule

// ==== source/link_cfg_if.sv ====
`timescale 1ns/1ps

interface link_cfg_if;
	import io_links_pkg::*;

	// Settings from the register block
	logic [offset_w-1:0] bit_offset;
	logic                invert;
	logic                tristate;
	logic                bypass;
	logic                lane_rst;

	// One pulse per rebuilt word
	logic                word_done;

	modport regs (
		output bit_offset,
		output invert,
		output tristate,
		output bypass,
		output lane_rst,
		input  word_done
	);

	modport lane (
		input  bit_offset,
		input  invert,
		input  tristate,
		input  bypass,
		input  lane_rst,
		output word_done
	);

endinterface

// ==== source/link_deserializer.sv ====
`timescale 1ns/1ps

module link_deserializer (
	input  logic                              in_clk160,
	input  logic                              rst_n,
	input  logic                              lane_rst,
	input  logic [io_links_pkg::offset_w-1:0] bit_offset,
	input  logic                              line_bit,
	input  logic                              line_en,
	output logic [io_links_pkg::word_w-1:0]   word,
	output logic                              word_valid
);
	import io_links_pkg::*;

	logic [word_w-1:0]    hist_q;
	logic [offset_w-1:0]  skip_cnt;
	logic [bit_cnt_w-1:0] bit_cnt;
	logic                 full_q;
	logic                 skipping;
	logic                 take;

	// Leading bits dropped to emulate the input delay tap
	assign skipping = (skip_cnt < bit_offset);
	assign take     = line_en && !skipping;

	////////////////////////////////////////////////////////////////////
	// Stream position
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			skip_cnt   <= '0;
			bit_cnt    <= '0;
			full_q     <= 1'b0;
			word_valid <= 1'b0;
		end else if (lane_rst) begin
			skip_cnt   <= '0;
			bit_cnt    <= '0;
			full_q     <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			if (line_en && skipping)
				skip_cnt <= skip_cnt + 1'b1;
			if (take)
				bit_cnt <= bit_cnt + 1'b1;
			full_q     <= take && (bit_cnt == last_bit);
			word_valid <= full_q;
		end
	end

	// History keeps shifting while the finished word is copied out
	always_ff @(posedge in_clk160) begin
		if (take)
			hist_q <= {hist_q[word_w-2:0], line_bit};
		if (full_q)
			word <= hist_q;
	end

endmodule

// ==== source/link_lane.sv ====
`timescale 1ns/1ps

module link_lane (
	input  logic                            in_clk160,
	input  logic                            rst_n,
	link_cfg_if.lane                        cfg,
	input  logic [io_links_pkg::word_w-1:0] in_tdata,
	input  logic                            in_tvalid,
	output logic                            in_tready,
	output logic [io_links_pkg::word_w-1:0] out_tdata,
	output logic                            out_tvalid,
	output logic                            line_bit_out,
	output logic                            line_en_out,
	input  logic                            line_bit_in,
	input  logic                            line_en_in
);
	import io_links_pkg::*;

	logic [word_w-1:0] inv_mask;
	logic [word_w-1:0] des_word;
	logic [word_w-1:0] byp_data;
	logic              des_valid;
	logic              byp_valid;
	logic              accept;

	assign inv_mask = {word_w{cfg.invert}};
	assign accept   = in_tvalid && in_tready;

	link_serializer ser_inst (
		.in_clk160  (in_clk160),
		.rst_n      (rst_n),
		.lane_rst   (cfg.lane_rst),
		.tristate   (cfg.tristate),
		.word       (in_tdata ^ inv_mask),
		.word_valid (in_tvalid),
		.word_ready (in_tready),
		.line_bit   (line_bit_out),
		.line_en    (line_en_out)
	);

	link_deserializer des_inst (
		.in_clk160  (in_clk160),
		.rst_n      (rst_n),
		.lane_rst   (cfg.lane_rst),
		.bit_offset (cfg.bit_offset),
		.line_bit   (line_bit_in),
		.line_en    (line_en_in),
		.word       (des_word),
		.word_valid (des_valid)
	);

	////////////////////////////////////////////////////////////////////
	// Bypass path with one register stage
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n)
			byp_valid <= 1'b0;
		else if (cfg.lane_rst)
			byp_valid <= 1'b0;
		else
			byp_valid <= accept;
	end

	always_ff @(posedge in_clk160) begin
		if (accept)
			byp_data <= in_tdata;
	end

	// Output select
	assign out_tdata     = cfg.bypass ? byp_data : (des_word ^ inv_mask);
	assign out_tvalid    = cfg.bypass ? byp_valid : des_valid;
	assign cfg.word_done = des_valid && !cfg.bypass;

endmodule

// ==== source/link_serializer.sv ====
`timescale 1ns/1ps

module link_serializer (
	input  logic                            in_clk160,
	input  logic                            rst_n,
	input  logic                            lane_rst,
	input  logic                            tristate,
	input  logic [io_links_pkg::word_w-1:0] word,
	input  logic                            word_valid,
	output logic                            word_ready,
	output logic                            line_bit,
	output logic                            line_en
);
	import io_links_pkg::*;

	logic [word_w-1:0]    shift_q;
	logic [bit_cnt_w-1:0] bit_cnt;
	logic                 busy;
	logic                 ready_q;
	logic                 accept;

	assign word_ready = ready_q && !lane_rst;
	assign accept     = word_valid && word_ready;

	always_ff @(posedge in_clk160 or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			ready_q <= 1'b0;
		end else if (lane_rst) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			ready_q <= 1'b0;
		end else if (accept) begin
			busy    <= 1'b1;
			bit_cnt <= '0;
			ready_q <= 1'b0;
		end else if (busy) begin
			bit_cnt <= bit_cnt + 1'b1;
			busy    <= (bit_cnt != last_bit);
			// Open up while the last bit is on the line
			ready_q <= (bit_cnt >= last_bit - 1'b1);
		end else begin
			ready_q <= 1'b1;
		end
	end

	// MSB first
	always_ff @(posedge in_clk160) begin
		if (accept)
			shift_q <= word;
		else if (busy)
			shift_q <= {shift_q[word_w-2:0], 1'b0};
	end

	assign line_bit = shift_q[word_w-1];
	assign line_en  = busy && !tristate;

endmodule

// ==== tb.f ====
source/io_links_pkg.sv
source/link_cfg_if.sv
source/apb_link_regs.sv
source/link_serializer.sv
source/link_deserializer.sv
source/link_lane.sv
source/io_links_top.sv
sim/io_links_checker.sv
sim/tb_io_links.sv
